// File: src/RecoveryTypes.sv
// Recovery types for the issue queue.
// Active-list pointer, the flush range of a misprediction and
// the circular range check used by selective flush.

package RecoveryTypes;

    // Active list has 64 slots and wraps
    typedef logic [5:0] AlPtr;

    typedef struct packed {
        AlPtr head;
        AlPtr tail;
    } FlushRange;

    // True when ptr lies in [head, tail) on the circular active list
    function automatic logic InFlushRange(input AlPtr ptr, input FlushRange range);
        logic inRange;
        if (range.head <= range.tail) begin
            inRange = (ptr >= range.head) && (ptr < range.tail);
        end else begin
            // Range wraps past the last slot
            inRange = (ptr >= range.head) || (ptr < range.tail);
        end
        return inRange;
    endfunction

endpackage

// File: src/SchedulerTypes.sv
// Scheduler types for the issue queue.
// Entry index and tag types, the op payload word and the
// dispatch and issue records.

package SchedulerTypes;
    import RecoveryTypes::*;

    // Ops dispatched per cycle, fixed by the record arrays below
    localparam int DispatchWidth = 2;

    // Sized for the largest queue of 16 entries
    typedef logic [3:0] IqIndex;

    typedef logic [5:0] RegTag;

    typedef enum logic {
        ClassInt = 1'b0,
        ClassMem = 1'b1
    } OpClass;

    typedef struct packed {
        logic [3:0]  aluCode;
        RegTag       destTag;
        logic [21:0] imm;
    } IntPayload;

    typedef struct packed {
        logic        isStore;
        logic [2:0]  size;
        RegTag       destTag;
        logic [21:0] offset;
    } MemPayload;

    // One payload word, decoded by op class
    typedef union packed {
        IntPayload intOp;
        MemPayload memOp;
    } OpPayload;

    typedef struct packed {
        OpClass   opClass;
        RegTag    srcTag;
        logic     srcReady;
        AlPtr     alPtr;
        OpPayload payload;
    } DispatchOp;

    typedef struct packed {
        OpClass   opClass;
        IqIndex   index;
        OpPayload payload;
    } IssuedOp;

endpackage

// File: src/IqFreeList.sv
// Issue queue free list.
// Circular list of free entry indices, up to two pops and
// PushWidth pushes per cycle, with a restore to a full list.

`timescale 1ns/10ps

module IqFreeList
    import SchedulerTypes::*;
#(
    parameter int EntryNum  = 16,
    parameter int PushWidth = 5
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       restore,
    input  logic [DispatchWidth-1:0]   pop,
    output IqIndex                     poppedIndex [DispatchWidth],
    input  logic [PushWidth-1:0]       push,
    input  IqIndex                     pushedIndex [PushWidth],
    output logic [$clog2(EntryNum):0]  count
);

    localparam int PtrWidth   = $clog2(EntryNum);
    localparam int CountWidth = $clog2(EntryNum) + 1;

    IqIndex              entries [EntryNum];
    logic [PtrWidth-1:0] headPtr;
    logic [PtrWidth-1:0] tailPtr;
    logic [PtrWidth-1:0] pushSlot [PushWidth];
    int                  popCount;
    int                  pushCount;

    function automatic logic [PtrWidth-1:0] wrapPtr(input logic [PtrWidth-1:0] base,
                                                    input int offset);
        int sum;
        sum = (int'(base) + offset) % EntryNum;
        return PtrWidth'(sum);
    endfunction

    always_comb begin
        popCount = 0;
        for (int i = 0; i < DispatchWidth; i++) begin
            poppedIndex[i] = entries[wrapPtr(headPtr, i)];
            if (pop[i]) begin
                popCount = popCount + 1;
            end
        end
        // Pushed lanes are packed onto the tail, skipping idle lanes
        pushCount = 0;
        for (int i = 0; i < PushWidth; i++) begin
            pushSlot[i] = wrapPtr(tailPtr, pushCount);
            if (push[i]) begin
                pushCount = pushCount + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (restore) begin
            for (int i = 0; i < EntryNum; i++) begin
                entries[i] <= IqIndex'(i);
            end
        end else begin
            for (int i = 0; i < PushWidth; i++) begin
                if (push[i]) begin
                    entries[pushSlot[i]] <= pushedIndex[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= '0;
        end else if (restore) begin
            headPtr <= '0;
            tailPtr <= '0;
            count   <= CountWidth'(EntryNum);
        end else begin
            headPtr <= wrapPtr(headPtr, popCount);
            tailPtr <= wrapPtr(tailPtr, pushCount);
            count   <= CountWidth'(int'(count) + pushCount - popCount);
        end
    end

endmodule

// File: src/IqPayloadRam.sv
// Issue queue payload RAM.
// Distributed RAM of payload words, two write ports and one
// asynchronous read port.

`timescale 1ns/10ps

module IqPayloadRam
    import SchedulerTypes::*;
#(
    parameter int EntryNum = 16
) (
    input  logic                     clk,
    input  logic [DispatchWidth-1:0] writeEnable,
    input  IqIndex                   writeIndex [DispatchWidth],
    input  OpPayload                 writeData [DispatchWidth],
    input  IqIndex                   readIndex,
    output OpPayload                 readData
);

    OpPayload mem [EntryNum];

    // Later lane wins when both lanes hit one entry
    always_ff @(posedge clk) begin
        for (int i = 0; i < DispatchWidth; i++) begin
            if (writeEnable[i]) begin
                mem[writeIndex[i]] <= writeData[i];
            end
        end
    end

    assign readData = mem[readIndex];

endmodule

// File: src/IqWakeupSelect.sv
// Wakeup and select for the issue queue.
// Tracks waiting and ready state per entry, wakes entries on a
// tag broadcast and picks the lowest-index ready entry.

`timescale 1ns/10ps

module IqWakeupSelect
    import SchedulerTypes::*;
#(
    parameter int EntryNum = 16
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [DispatchWidth-1:0] write,
    input  IqIndex                   writeIndex [DispatchWidth],
    input  DispatchOp                writeOp [DispatchWidth],
    input  logic                     wakeupValid,
    input  RegTag                    wakeupTag,
    input  logic [EntryNum-1:0]      flush,
    output logic                     selectValid,
    output IqIndex                   selectIndex,
    output logic [EntryNum-1:0]      waiting
);

    logic [EntryNum-1:0] waitingReg;
    logic [EntryNum-1:0] readyReg;
    logic [EntryNum-1:0] candidate;
    RegTag               srcTag [EntryNum];

    // Entries being flushed this cycle never issue
    assign candidate = waitingReg & readyReg & ~flush;
    assign waiting   = waitingReg;

    // Lowest index has priority
    always_comb begin
        selectValid = 1'b0;
        selectIndex = '0;
        for (int i = EntryNum - 1; i >= 0; i--) begin
            if (candidate[i]) begin
                selectValid = 1'b1;
                selectIndex = IqIndex'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            waitingReg <= '0;
            readyReg   <= '0;
        end else begin
            // Tag broadcast
            for (int i = 0; i < EntryNum; i++) begin
                if (waitingReg[i] && wakeupValid && (srcTag[i] == wakeupTag)) begin
                    readyReg[i] <= 1'b1;
                end
                if (flush[i]) begin
                    waitingReg[i] <= 1'b0;
                end
            end
            // No stall on the issue port, so a pick is also a release
            if (selectValid) begin
                waitingReg[selectIndex] <= 1'b0;
            end
            for (int l = 0; l < DispatchWidth; l++) begin
                if (write[l]) begin
                    waitingReg[writeIndex[l]] <= 1'b1;
                    // Same-cycle broadcast also catches a dispatching op
                    readyReg[writeIndex[l]] <= writeOp[l].srcReady ||
                        (wakeupValid && (wakeupTag == writeOp[l].srcTag));
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < DispatchWidth; l++) begin
            if (write[l]) begin
                srcTag[writeIndex[l]] <= writeOp[l].srcTag;
            end
        end
    end

endmodule

// File: src/IssueQueue.sv
// Issue queue allocator and payload storage.
// Hands out free entries to dispatch, keeps each entry's
// active-list pointer, detects selective flush, returns flushed
// entries to the free list and rebuilds it on commit recovery.

`timescale 1ns/10ps

module IssueQueue
    import SchedulerTypes::*;
    import RecoveryTypes::*;
#(
    parameter int EntryNum    = 16,
    parameter int ReturnWidth = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [DispatchWidth-1:0] dispatchValid,
    input  DispatchOp                dispatchOp [DispatchWidth],
    output logic                     allocatable,
    output logic [DispatchWidth-1:0] writeEnable,
    output IqIndex                   writeIndex [DispatchWidth],
    input  logic                     selectValid,
    input  IqIndex                   selectIndex,
    input  logic [EntryNum-1:0]      waiting,
    input  logic                     recoverValid,
    input  logic                     recoverFromCommit,
    input  FlushRange                flushRange,
    output logic [EntryNum-1:0]      flush,
    output AlPtr                     selectedAlPtr,
    input  IqIndex                   readIndex,
    output OpPayload                 readData
);

    localparam int PushWidth         = 1 + ReturnWidth;
    localparam int RecoveryCycles    = EntryNum / ReturnWidth;
    localparam int OffsetWidth       = $clog2(EntryNum);
    localparam int RestoreCountWidth = $clog2(RecoveryCycles + 1);

    IqIndex                      poppedIndex [DispatchWidth];
    logic [$clog2(EntryNum):0]   freeCount;
    logic [PushWidth-1:0]        push;
    IqIndex                      pushedIndex [PushWidth];
    OpPayload                    writeData [DispatchWidth];
    AlPtr                        alPtrReg [EntryNum];
    logic                        selectiveRecover;
    logic                        commitRecover;
    logic                        restore;
    logic                        restoreActive;
    logic [RestoreCountWidth-1:0] restoreCount;
    logic                        sweepActive;
    logic [OffsetWidth-1:0]      sweepOffset;
    logic [EntryNum-1:0]         returnVector;
    logic [EntryNum-1:0]         sweepMask;

    IqFreeList #(
        .EntryNum (EntryNum),
        .PushWidth(PushWidth)
    ) u_freeList (
        .clk        (clk),
        .reset      (reset),
        .restore    (restore),
        .pop        (writeEnable),
        .poppedIndex(poppedIndex),
        .push       (push),
        .pushedIndex(pushedIndex),
        .count      (freeCount)
    );

    IqPayloadRam #(
        .EntryNum(EntryNum)
    ) u_payloadRam (
        .clk        (clk),
        .writeEnable(writeEnable),
        .writeIndex (writeIndex),
        .writeData  (writeData),
        .readIndex  (readIndex),
        .readData   (readData)
    );

    // Allocation
    always_comb begin
        int slot;
        selectiveRecover = recoverValid && !recoverFromCommit;
        commitRecover    = recoverValid && recoverFromCommit;
        allocatable      = !restoreActive && (freeCount >= DispatchWidth);
        // Accepted lanes take free-list heads in order
        slot = 0;
        for (int i = 0; i < DispatchWidth; i++) begin
            writeEnable[i] = dispatchValid[i] && allocatable && !commitRecover;
            writeIndex[i]  = poppedIndex[slot];
            writeData[i]   = dispatchOp[i].payload;
            if (writeEnable[i]) begin
                slot = slot + 1;
            end
        end
    end

    // Copy of each entry's active-list pointer
    always_ff @(posedge clk) begin
        for (int i = 0; i < DispatchWidth; i++) begin
            if (writeEnable[i]) begin
                alPtrReg[writeIndex[i]] <= dispatchOp[i].alPtr;
            end
        end
    end

    assign selectedAlPtr = alPtrReg[selectIndex];

    // Flush detection, commit recovery drops everything
    always_comb begin
        for (int i = 0; i < EntryNum; i++) begin
            flush[i] = commitRecover ||
                (selectiveRecover && waiting[i] && InFlushRange(alPtrReg[i], flushRange));
        end
    end

    // Release from select on lane 0, sweep returns on the others
    always_comb begin
        push[0]        = selectValid;
        pushedIndex[0] = selectIndex;
        sweepMask      = '0;
        for (int j = 0; j < ReturnWidth; j++) begin
            push[1 + j]        = sweepActive && returnVector[int'(sweepOffset) + j];
            pushedIndex[1 + j] = IqIndex'(int'(sweepOffset) + j);
            sweepMask[int'(sweepOffset) + j] = sweepActive;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || commitRecover) begin
            sweepActive  <= 1'b0;
            sweepOffset  <= '0;
            returnVector <= '0;
        end else if (selectiveRecover) begin
            // Unreturned entries of an earlier sweep are kept
            sweepActive  <= 1'b1;
            sweepOffset  <= '0;
            returnVector <= (returnVector & ~sweepMask) | flush;
        end else if (sweepActive) begin
            returnVector <= returnVector & ~sweepMask;
            if (sweepOffset == OffsetWidth'(EntryNum - ReturnWidth)) begin
                sweepActive <= 1'b0;
                sweepOffset <= '0;
            end else begin
                sweepOffset <= sweepOffset + OffsetWidth'(ReturnWidth);
            end
        end
    end

    // Restore sequence, also started by reset
    assign restore = restoreActive &&
        (restoreCount == RestoreCountWidth'(RecoveryCycles - 1));

    always_ff @(posedge clk) begin
        if (reset || commitRecover) begin
            restoreActive <= 1'b1;
            restoreCount  <= '0;
        end else if (restore) begin
            restoreActive <= 1'b0;
            restoreCount  <= '0;
        end else if (restoreActive) begin
            restoreCount <= restoreCount + 1'b1;
        end
    end

endmodule

// File: src/IssueQueueTop.sv
// Issue queue top level.
// Joins the allocator, wakeup/select and the issue output
// register, which is killed by a covering selective flush.

`timescale 1ns/10ps

module IssueQueueTop
    import SchedulerTypes::*;
    import RecoveryTypes::*;
#(
    parameter int EntryNum    = 16,
    parameter int ReturnWidth = 4
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [DispatchWidth-1:0] dispatchValid,
    input  DispatchOp                dispatchOp [DispatchWidth],
    output logic                     allocatable,
    input  logic                     wakeupValid,
    input  RegTag                    wakeupTag,
    input  logic                     recoverValid,
    input  logic                     recoverFromCommit,
    input  FlushRange                flushRange,
    output logic                     issueValid,
    output IssuedOp                  issuedOp
);

    logic [DispatchWidth-1:0] writeEnable;
    IqIndex                   writeIndex [DispatchWidth];
    logic                     selectValid;
    IqIndex                   selectIndex;
    logic [EntryNum-1:0]      waiting;
    logic [EntryNum-1:0]      flush;
    AlPtr                     selectedAlPtr;
    OpPayload                 readData;
    OpClass                   entryClass [EntryNum];
    logic                     issueValidReg;
    IssuedOp                  issuedOpReg;
    AlPtr                     issueAlPtrReg;

    IssueQueue #(
        .EntryNum   (EntryNum),
        .ReturnWidth(ReturnWidth)
    ) u_issueQueue (
        .clk              (clk),
        .reset            (reset),
        .dispatchValid    (dispatchValid),
        .dispatchOp       (dispatchOp),
        .allocatable      (allocatable),
        .writeEnable      (writeEnable),
        .writeIndex       (writeIndex),
        .selectValid      (selectValid),
        .selectIndex      (selectIndex),
        .waiting          (waiting),
        .recoverValid     (recoverValid),
        .recoverFromCommit(recoverFromCommit),
        .flushRange       (flushRange),
        .flush            (flush),
        .selectedAlPtr    (selectedAlPtr),
        .readIndex        (selectIndex),
        .readData         (readData)
    );

    IqWakeupSelect #(
        .EntryNum(EntryNum)
    ) u_wakeupSelect (
        .clk        (clk),
        .reset      (reset),
        .write      (writeEnable),
        .writeIndex (writeIndex),
        .writeOp    (dispatchOp),
        .wakeupValid(wakeupValid),
        .wakeupTag  (wakeupTag),
        .flush      (flush),
        .selectValid(selectValid),
        .selectIndex(selectIndex),
        .waiting    (waiting)
    );

    // Op class per entry, the payload RAM only keeps the union word
    always_ff @(posedge clk) begin
        for (int i = 0; i < DispatchWidth; i++) begin
            if (writeEnable[i]) begin
                entryClass[writeIndex[i]] <= dispatchOp[i].opClass;
            end
        end
    end

    // Issue register, reloaded every cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            issueValidReg <= 1'b0;
        end else begin
            issueValidReg <= selectValid;
        end
    end

    always_ff @(posedge clk) begin
        issuedOpReg.opClass <= entryClass[selectIndex];
        issuedOpReg.index   <= selectIndex;
        issuedOpReg.payload <= readData;
        issueAlPtrReg       <= selectedAlPtr;
    end

    // An op already selected is dropped when the flush covers it
    assign issueValid = issueValidReg &&
        !(recoverValid && !recoverFromCommit && InFlushRange(issueAlPtrReg, flushRange));
    assign issuedOp = issuedOpReg;

endmodule

// File: verification/IssueQueueTb.sv
// Testbench for the issue queue top level.
// Directed tests for allocation, ordered issue, tag wakeup,
// selective flush and commit recovery, checked against a small
// reference model of the queue and its free list.

`timescale 1ns/10ps

module IssueQueueTb
    import SchedulerTypes::*;
    import RecoveryTypes::*;
;

    localparam int EntryNum      = 16;
    localparam int ReturnWidth   = 4;
    localparam int ClkPeriod     = 20;
    localparam int StimDelay     = 2;
    localparam int ResetCycles   = 8;
    localparam int TestCount     = 5;
    localparam int CyclesPerTest = 200;
    localparam int IssueTimeout  = 60;
    localparam int QuietCycles   = 10;

    logic                     clk;
    logic                     reset;
    logic [DispatchWidth-1:0] dispatchValid;
    DispatchOp                dispatchOp [DispatchWidth];
    logic                     allocatable;
    logic                     wakeupValid;
    RegTag                    wakeupTag;
    logic                     recoverValid;
    logic                     recoverFromCommit;
    FlushRange                flushRange;
    logic                     issueValid;
    IssuedOp                  issuedOp;

    // Reference model
    DispatchOp   modelOp [EntryNum];
    logic        modelWaiting [EntryNum];
    int          freeQ [$];
    IssuedOp     observed [$];
    logic [31:0] lfsrState;
    int          checks;
    int          errors;

    IssueQueueTop #(
        .EntryNum   (EntryNum),
        .ReturnWidth(ReturnWidth)
    ) u_dut (
        .clk              (clk),
        .reset            (reset),
        .dispatchValid    (dispatchValid),
        .dispatchOp       (dispatchOp),
        .allocatable      (allocatable),
        .wakeupValid      (wakeupValid),
        .wakeupTag        (wakeupTag),
        .recoverValid     (recoverValid),
        .recoverFromCommit(recoverFromCommit),
        .flushRange       (flushRange),
        .issueValid       (issueValid),
        .issuedOp         (issuedOp)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Issue monitor, samples mid-cycle
    always @(negedge clk) begin
        if (!reset && issueValid) begin
            observed.push_back(issuedOp);
        end
    end

    // Watchdog
    initial begin
        #(TestCount * CyclesPerTest * ClkPeriod);
        $display("Simulation timed out before all tests finished");
        $display("Regression failed");
        $finish;
    end

    task automatic nextCycle();
        @(posedge clk);
        #StimDelay;
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic randomBit();
        logic fb;
        fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
        lfsrState = {lfsrState[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randomBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], randomBit()};
        end
        return value;
    endfunction

    // In range when the distance from head is below the range length
    function automatic logic inCircularRange(input AlPtr ptr, input AlPtr head, input AlPtr tail);
        int offset;
        int length;
        offset = (int'(ptr) - int'(head) + 64) % 64;
        length = (int'(tail) - int'(head) + 64) % 64;
        return offset < length;
    endfunction

    task automatic checkIssued(input IssuedOp got, input IssuedOp expected, input string what);
        logic match;
        checks++;
        match = (got.opClass == expected.opClass) && (got.index == expected.index);
        // Payload decoded by op class
        if (expected.opClass == ClassInt) begin
            match = match && (got.payload.intOp == expected.payload.intOp);
        end else begin
            match = match && (got.payload.memOp == expected.payload.memOp);
        end
        if (!match) begin
            errors++;
            $display(
                "[FAIL] %0t: %s got index %0d class %0d %h, expected index %0d class %0d %h",
                $time, what, got.index, got.opClass, got.payload,
                expected.index, expected.opClass, expected.payload);
        end
    endtask

    task automatic checkBit(input logic got, input logic expected, input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("[FAIL] %0t: %s got %b, expected %b", $time, what, got, expected);
        end
    endtask

    task automatic checkCount(input int got, input int expected, input string what);
        checks++;
        if (got != expected) begin
            errors++;
            $display("[FAIL] %0t: %s got %0d, expected %0d", $time, what, got, expected);
        end
    endtask

    task automatic resetModel();
        freeQ.delete();
        for (int i = 0; i < EntryNum; i++) begin
            modelWaiting[i] = 1'b0;
            freeQ.push_back(i);
        end
    endtask

    task automatic waitAllocatable();
        int cycles;
        cycles = 0;
        while (!allocatable && cycles < IssueTimeout) begin
            nextCycle();
            cycles++;
        end
        if (!allocatable) begin
            errors++;
            $display("Error at %0t: allocatable never rose", $time);
        end
    endtask

    function automatic DispatchOp makeOp(input RegTag tag, input AlPtr alPtr);
        DispatchOp op;
        op.opClass  = randomBit() ? ClassMem : ClassInt;
        op.srcTag   = tag;
        op.srcReady = 1'b0;
        op.alPtr    = alPtr;
        if (op.opClass == ClassInt) begin
            op.payload.intOp.aluCode = 4'(randomBits(4));
            op.payload.intOp.destTag = 6'(randomBits(6));
            op.payload.intOp.imm     = 22'(randomBits(22));
        end else begin
            op.payload.memOp.isStore = randomBit();
            op.payload.memOp.size    = 3'(randomBits(3));
            op.payload.memOp.destTag = 6'(randomBits(6));
            op.payload.memOp.offset  = 22'(randomBits(22));
        end
        return op;
    endfunction

    task automatic recordOp(input DispatchOp op);
        int idx;
        idx = freeQ.pop_front();
        modelOp[idx]      = op;
        modelWaiting[idx] = 1'b1;
    endtask

    // Called mid-cycle with allocatable high
    task automatic dispatchPair(input DispatchOp op0, input DispatchOp op1);
        if (freeQ.size() < 2) begin
            errors++;
            $display("Error at %0t: allocatable is high but fewer than two entries are free",
                $time);
            nextCycle();
            return;
        end
        dispatchValid = 2'b11;
        dispatchOp[0] = op0;
        dispatchOp[1] = op1;
        recordOp(op0);
        recordOp(op1);
        nextCycle();
        dispatchValid = 2'b00;
    endtask

    task automatic fillQueue(input int baseTag, input int tagSpread, input int alBase,
                             output int allocated);
        DispatchOp op0;
        DispatchOp op1;
        allocated = 0;
        while (allocatable && allocated < EntryNum) begin
            op0 = makeOp(RegTag'(baseTag + allocated % tagSpread),
                         AlPtr'((alBase + 2 * allocated) % 64));
            op1 = makeOp(RegTag'(baseTag + (allocated + 1) % tagSpread),
                         AlPtr'((alBase + 2 * (allocated + 1)) % 64));
            dispatchPair(op0, op1);
            allocated += 2;
        end
    endtask

    // Broadcast one tag, then expect exactly the matching ops in index order
    task automatic wakeAndCheck(input RegTag tag);
        int      expIdx [$];
        int      cycles;
        IssuedOp expected;
        for (int i = 0; i < EntryNum; i++) begin
            if (modelWaiting[i] && modelOp[i].srcTag == tag) begin
                expIdx.push_back(i);
            end
        end
        observed.delete();
        wakeupValid = 1'b1;
        wakeupTag   = tag;
        nextCycle();
        wakeupValid = 1'b0;
        cycles = 0;
        while (observed.size() < expIdx.size() && cycles < IssueTimeout) begin
            nextCycle();
            cycles++;
        end
        if (observed.size() < expIdx.size()) begin
            errors++;
            $display("Error at %0t: only %0d of %0d ops issued after wakeup of tag %0d",
                $time, observed.size(), expIdx.size(), tag);
        end
        repeat (QuietCycles) nextCycle();
        checkCount(observed.size(), expIdx.size(), "issue count after wakeup");
        foreach (expIdx[k]) begin
            expected.opClass = modelOp[expIdx[k]].opClass;
            expected.index   = IqIndex'(expIdx[k]);
            expected.payload = modelOp[expIdx[k]].payload;
            if (k < observed.size()) begin
                checkIssued(observed[k], expected, "issued op");
            end
            modelWaiting[expIdx[k]] = 1'b0;
            freeQ.push_back(expIdx[k]);
        end
    endtask

    task automatic selectiveFlush(input AlPtr head, input AlPtr tail);
        recoverValid      = 1'b1;
        recoverFromCommit = 1'b0;
        flushRange.head   = head;
        flushRange.tail   = tail;
        // Sweep returns flushed entries in ascending order
        for (int i = 0; i < EntryNum; i++) begin
            if (modelWaiting[i] && inCircularRange(modelOp[i].alPtr, head, tail)) begin
                modelWaiting[i] = 1'b0;
                freeQ.push_back(i);
            end
        end
        nextCycle();
        recoverValid = 1'b0;
        repeat (EntryNum / ReturnWidth + 2) nextCycle();
    endtask

    task automatic testResetAndFill();
        int allocated;
        checkBit(allocatable, 1'b0, "allocatable during restore after reset");
        checkBit(issueValid, 1'b0, "issueValid after reset");
        waitAllocatable();
        observed.delete();
        fillQueue(10, 1, 0, allocated);
        checkCount(allocated, EntryNum, "entries allocated after reset");
        checkBit(allocatable, 1'b0, "allocatable with a full queue");
        repeat (QuietCycles) nextCycle();
        checkCount(observed.size(), 0, "issues with no ready op");
    endtask

    task automatic testOrderedIssue();
        wakeAndCheck(10);
        checkBit(allocatable, 1'b1, "allocatable after the queue drained");
    endtask

    task automatic testTagWakeup();
        int allocated;
        fillQueue(20, 4, 8, allocated);
        checkCount(allocated, EntryNum, "entries allocated for tag wakeup");
        wakeAndCheck(21);
        wakeAndCheck(20);
        wakeAndCheck(22);
        wakeAndCheck(23);
    endtask

    task automatic testSelectiveFlush();
        int allocated;
        int expFree;
        fillQueue(30, 1, 54, allocated);
        checkCount(allocated, EntryNum, "entries allocated before flush");
        // Range wraps past the last active-list slot
        selectiveFlush(AlPtr'(58), AlPtr'(6));
        wakeAndCheck(30);
        expFree = freeQ.size();
        fillQueue(31, 1, 32, allocated);
        checkCount(allocated, expFree - expFree % 2, "entries allocated after flush sweep");
        checkBit(allocatable, 1'b0, "allocatable after refill");
    endtask

    task automatic testCommitRecovery();
        int lowCycles;
        int allocated;
        recoverValid      = 1'b1;
        recoverFromCommit = 1'b1;
        resetModel();
        nextCycle();
        recoverValid      = 1'b0;
        recoverFromCommit = 1'b0;
        lowCycles = 0;
        while (!allocatable && lowCycles < IssueTimeout) begin
            lowCycles++;
            nextCycle();
        end
        checkCount(lowCycles, EntryNum / ReturnWidth, "cycles with allocatable low in restore");
        wakeAndCheck(31);
        fillQueue(40, 1, 12, allocated);
        checkCount(allocated, EntryNum, "entries allocated after commit recovery");
        wakeAndCheck(40);
    endtask

    initial begin
        reset             = 1'b1;
        dispatchValid     = '0;
        dispatchOp[0]     = '0;
        dispatchOp[1]     = '0;
        wakeupValid       = 1'b0;
        wakeupTag         = '0;
        recoverValid      = 1'b0;
        recoverFromCommit = 1'b0;
        flushRange        = '0;
        lfsrState         = 32'hbf5c0f9d;
        checks            = 0;
        errors            = 0;
        resetModel();
        repeat (ResetCycles) @(posedge clk);
        #StimDelay;
        reset = 1'b0;

        testResetAndFill();
        testOrderedIssue();
        testTagWakeup();
        testSelectiveFlush();
        testCommitRecovery();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/RecoveryTypes.sv
src/SchedulerTypes.sv
src/IqFreeList.sv
src/IqPayloadRam.sv
src/IqWakeupSelect.sv
src/IssueQueue.sv
src/IssueQueueTop.sv
verification/IssueQueueTb.sv

// File: Makefile
# Verilator build and run of the issue queue testbench

SIM := obj_dir/VIssueQueueTb

all: run

$(SIM): vlog.f $(wildcard src/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing -Wno-fatal --top-module IssueQueueTb -f vlog.f

run: $(SIM)
	$(SIM) | tee sim.log
	grep -qx "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
